// File: tb.f
+incdir+common
common/eth_types_pkg.sv
common/host_types_pkg.sv
rx_port/gmii_rx_deframer.sv
rx_port/rx_byte_packer.sv
rx_port/rx_slot_ctrl.sv
logic/slot_ram.sv
logic/wb_slot_port.sv
logic/ethpipe_rx_top.sv
test/tb_ethpipe_rx.sv

// File: test/tb_ethpipe_rx.sv
`timescale 1ns/1ns
`default_nettype none

`include "ethpipe_params.svh"

module tb_ethpipe_rx;

  import eth_types_pkg::*;
  import host_types_pkg::*;

  localparam int CLK_PERIOD = 4;
  localparam int GAP        = 12;  // idle cycles after each frame
  localparam int FRAME_CYC  = 64 + 40 + 61 + 62 + 63 + 100 + 50 + 7 * (8 + 1 + GAP);
  localparam int HOST_CYC   = 800;
  localparam int WATCHDOG_NS = 2 * (FRAME_CYC + HOST_CYC) * CLK_PERIOD;

  logic       gmii_rx_clk;
  logic       sys_rst;
  gmii_byte_t gmii_rxd;
  logic       gmii_rx_dv;
  timestamp_t timestamp;
  logic       wb_cyc;
  logic       wb_stb;
  logic       wb_we;
  wb_addr_t   wb_adr;
  wb_sel_t    wb_sel;
  wb_data_t   wb_dat_w;
  wb_data_t   wb_dat_r;
  logic       wb_ack;

  integer     seed = 72222;
  int         err_count;
  int         other_count;
  gmii_byte_t exp_bytes [0:2047];
  int         exp_len;
  timestamp_t exp_ts;
  timestamp_t last_ts;  // timestamp at the latest rise of gmii_rx_dv
  logic       dv_q;

  ethpipe_rx_top UUT (
    .gmii_rx_clk(gmii_rx_clk),
    .sys_rst    (sys_rst),
    .gmii_rxd   (gmii_rxd),
    .gmii_rx_dv (gmii_rx_dv),
    .timestamp  (timestamp),
    .wb_cyc     (wb_cyc),
    .wb_stb     (wb_stb),
    .wb_we      (wb_we),
    .wb_adr     (wb_adr),
    .wb_sel     (wb_sel),
    .wb_dat_w   (wb_dat_w),
    .wb_dat_r   (wb_dat_r),
    .wb_ack     (wb_ack)
  );

  always #(CLK_PERIOD / 2) gmii_rx_clk = ~gmii_rx_clk;

  always @(negedge gmii_rx_clk) timestamp <= timestamp + 64'd1;  // card counter

  always @(posedge gmii_rx_clk) begin
    if (gmii_rx_dv && !dv_q) last_ts <= timestamp;
    dv_q <= gmii_rx_dv;
  end

  // --------------------
  // reference model
  // --------------------
  function automatic slot_word_t slot_expect(input int idx);
    slot_word_t word;
    int k;
    word = '0;
    case (idx)
      `HDR_TS_LO: word = exp_ts[31:0];
      `HDR_TS_HI: word = exp_ts[63:32];
      `HDR_RSVD:  word = '0;
      `HDR_LEN:   word = slot_word_t'(exp_len);
      default: begin
        for (int lane = 0; lane < 4; lane++) begin
          k = (idx - `DATA_BASE) * 4 + lane;
          if (k < exp_len) word[lane*8 +: 8] = exp_bytes[k];
        end
      end
    endcase
    return word;
  endfunction

  // lanes past the last frame byte are not compared
  function automatic slot_word_t lane_mask(input int idx);
    slot_word_t mask;
    mask = '1;
    if (idx >= `DATA_BASE) begin
      for (int lane = 0; lane < 4; lane++) begin
        if ((idx - `DATA_BASE) * 4 + lane >= exp_len) mask[lane*8 +: 8] = 8'h00;
      end
    end
    return mask;
  endfunction

  task automatic check_value(input string name, input logic [31:0] got, input logic [31:0] exp);
    if (got !== exp) begin
      $display("[FAIL] t=%0t %s got %h expected %h", $time, name, got, exp);
      err_count++;
    end
  endtask

  // --------------------
  // host bus
  // --------------------
  task automatic wb_read(input wb_addr_t adr, output wb_data_t data);
    @(negedge gmii_rx_clk);
    wb_cyc = 1'b1;
    wb_stb = 1'b1;
    wb_we  = 1'b0;
    wb_adr = adr;
    wb_sel = 4'hf;
    @(negedge gmii_rx_clk);
    while (!wb_ack) @(negedge gmii_rx_clk);
    data = wb_dat_r;
    @(negedge gmii_rx_clk);  // held through the ack edge
    wb_cyc = 1'b0;
    wb_stb = 1'b0;
  endtask

  task automatic wb_write(input wb_addr_t adr, input wb_data_t data, input wb_sel_t sel);
    @(negedge gmii_rx_clk);
    wb_cyc   = 1'b1;
    wb_stb   = 1'b1;
    wb_we    = 1'b1;
    wb_adr   = adr;
    wb_sel   = sel;
    wb_dat_w = data;
    @(negedge gmii_rx_clk);
    while (!wb_ack) @(negedge gmii_rx_clk);
    @(negedge gmii_rx_clk);  // held through the ack edge
    wb_cyc = 1'b0;
    wb_stb = 1'b0;
    wb_we  = 1'b0;
  endtask

  task automatic check_status(input logic full, input logic [15:0] drops);
    wb_data_t st;
    wb_read('0, st);
    check_value("status slot_full", 32'(st[STAT_FULL_BIT]), 32'(full));
    check_value("status drop_count", 32'(st[STAT_DROP_MSB:STAT_DROP_LSB]), 32'(drops));
  endtask

  task automatic wait_full();
    wb_data_t st;
    int n;
    n = 0;
    st = '0;
    while (!st[STAT_FULL_BIT] && n < 200) begin
      wb_read('0, st);
      n++;
    end
    if (!st[STAT_FULL_BIT]) begin
      $display("status never reported a full slot after the frame was sent");
      other_count++;
    end
  endtask

  task automatic check_slot();
    wb_data_t got;
    int last;
    last = `DATA_BASE + (exp_len + 3) / 4 - 1;
    for (int w = 1; w <= last; w++) begin
      wb_read(wb_addr_t'(w), got);
      check_value($sformatf("slot word %0d", w), got & lane_mask(w),
                  slot_expect(w) & lane_mask(w));
    end
  endtask

  // --------------------
  // gmii frame driver
  // --------------------
  task automatic send_frame(input int len, input bit store, input int min_pre);
    int pre;
    gmii_byte_t b;
    pre = min_pre + ($unsigned($random(seed)) % (8 - min_pre));
    for (int i = 0; i < pre; i++) begin
      @(negedge gmii_rx_clk);
      gmii_rx_dv = 1'b1;
      gmii_rxd   = `GMII_PREAMBLE;
    end
    @(negedge gmii_rx_clk);
    gmii_rxd = `GMII_SFD;
    for (int i = 0; i < len; i++) begin
      b = $random(seed);
      if (store) exp_bytes[i] = b;
      @(negedge gmii_rx_clk);
      gmii_rxd = b;
    end
    if (store) exp_len = len;
    @(negedge gmii_rx_clk);
    gmii_rx_dv = 1'b0;
    gmii_rxd   = 8'h00;
    repeat (GAP) @(negedge gmii_rx_clk);
  endtask

  task automatic capture_and_check(input int len, input logic [15:0] drops);
    send_frame(len, 1'b1, 1);
    wait_full();
    exp_ts = last_ts;
    check_slot();
    check_status(1'b1, drops);
  endtask

  initial begin
    gmii_rx_clk = 1'b0;
    sys_rst     = 1'b1;
    gmii_rxd    = 8'h00;
    gmii_rx_dv  = 1'b0;
    timestamp   = 64'h0000_0007_ffff_ff80;
    wb_cyc      = 1'b0;
    wb_stb      = 1'b0;
    wb_we       = 1'b0;
    wb_adr      = '0;
    wb_sel      = '0;
    wb_dat_w    = '0;
    dv_q        = 1'b0;
    last_ts     = '0;
    err_count   = 0;
    other_count = 0;
    repeat (2) @(negedge gmii_rx_clk);
    sys_rst = 1'b0;

    check_status(1'b0, 16'd0);
    capture_and_check(64, 16'd0);

    // slot full, frame must be dropped
    send_frame(40, 1'b0, 1);
    check_status(1'b1, 16'd1);
    check_slot();

    for (int n = 61; n <= 63; n++) begin
      wb_write('0, 32'd1, 4'b0001);
      check_status(1'b0, 16'd1);
      capture_and_check(n, 16'd1);
    end

    // release while a frame is on the line
    fork
      send_frame(100, 1'b0, 7);
      begin
        // release lands in the preamble, before the sfd
        repeat (2) @(negedge gmii_rx_clk);
        wb_write('0, 32'd1, 4'b0001);
      end
    join
    check_status(1'b0, 16'd2);
    capture_and_check(50, 16'd2);

    $display("errors: %0d value mismatches, %0d other failures", err_count, other_count);
    if (err_count == 0 && other_count == 0) begin
      $display("test passed");
    end else begin
      $display("test failed");
    end
    $finish;
  end

  initial begin
    #(WATCHDOG_NS);
    $display("watchdog expired before the test sequence finished");
    $display("test failed");
    $finish;
  end

endmodule

`default_nettype wire

// File: logic/ethpipe_rx_top.sv
`timescale 1ns/1ns
`default_nettype none

module ethpipe_rx_top (
  input  wire                         gmii_rx_clk,
  input  wire                         sys_rst,
  input  wire eth_types_pkg::gmii_byte_t gmii_rxd,
  input  wire                         gmii_rx_dv,
  input  wire eth_types_pkg::timestamp_t timestamp,
  input  wire                         wb_cyc,
  input  wire                         wb_stb,
  input  wire                         wb_we,
  input  wire host_types_pkg::wb_addr_t wb_adr,
  input  wire host_types_pkg::wb_sel_t  wb_sel,
  input  wire host_types_pkg::wb_data_t wb_dat_w,
  output host_types_pkg::wb_data_t    wb_dat_r,
  output logic                        wb_ack
);

  import eth_types_pkg::*;

  // --------------------
  // receive side
  // --------------------
  logic       capture_en;
  logic       frame_start;
  logic       byte_valid;
  gmii_byte_t data_byte;
  logic       frame_end;
  frame_len_t byte_count;
  logic       frame_dropped;

  logic       pk_wr_en;
  slot_addr_t pk_addr;
  slot_word_t pk_data;
  slot_be_t   pk_be;

  logic        slot_wr_en;
  slot_addr_t  slot_wr_addr;
  slot_word_t  slot_wr_data;
  slot_be_t    slot_wr_be;
  logic        slot_full;
  logic [15:0] drop_count;

  // host side
  slot_addr_t rd_addr;
  slot_word_t rd_data;
  logic       slot_release;

  gmii_rx_deframer u_deframer (
    .gmii_rx_clk  (gmii_rx_clk),
    .sys_rst      (sys_rst),
    .gmii_rxd     (gmii_rxd),
    .gmii_rx_dv   (gmii_rx_dv),
    .capture_en   (capture_en),
    .frame_start  (frame_start),
    .byte_valid   (byte_valid),
    .data_byte    (data_byte),
    .frame_end    (frame_end),
    .byte_count   (byte_count),
    .frame_dropped(frame_dropped)
  );

  rx_byte_packer u_packer (
    .gmii_rx_clk(gmii_rx_clk),
    .sys_rst    (sys_rst),
    .frame_start(frame_start),
    .byte_valid (byte_valid),
    .data_byte  (data_byte),
    .frame_end  (frame_end),
    .pk_wr_en   (pk_wr_en),
    .pk_addr    (pk_addr),
    .pk_data    (pk_data),
    .pk_be      (pk_be)
  );

  rx_slot_ctrl u_ctrl (
    .gmii_rx_clk  (gmii_rx_clk),
    .sys_rst      (sys_rst),
    .gmii_rx_dv   (gmii_rx_dv),
    .timestamp    (timestamp),
    .frame_end    (frame_end),
    .byte_count   (byte_count),
    .frame_dropped(frame_dropped),
    .pk_wr_en     (pk_wr_en),
    .pk_addr      (pk_addr),
    .pk_data      (pk_data),
    .pk_be        (pk_be),
    .slot_release (slot_release),
    .capture_en   (capture_en),
    .slot_wr_en   (slot_wr_en),
    .slot_wr_addr (slot_wr_addr),
    .slot_wr_data (slot_wr_data),
    .slot_wr_be   (slot_wr_be),
    .slot_full    (slot_full),
    .drop_count   (drop_count)
  );

  slot_ram u_ram (
    .gmii_rx_clk(gmii_rx_clk),
    .wr_en      (slot_wr_en),
    .wr_addr    (slot_wr_addr),
    .wr_data    (slot_wr_data),
    .wr_be      (slot_wr_be),
    .rd_addr    (rd_addr),
    .rd_data    (rd_data)
  );

  wb_slot_port u_wb (
    .gmii_rx_clk (gmii_rx_clk),
    .sys_rst     (sys_rst),
    .wb_cyc      (wb_cyc),
    .wb_stb      (wb_stb),
    .wb_we       (wb_we),
    .wb_adr      (wb_adr),
    .wb_sel      (wb_sel),
    .wb_dat_w    (wb_dat_w),
    .rd_data     (rd_data),
    .slot_full   (slot_full),
    .drop_count  (drop_count),
    .wb_dat_r    (wb_dat_r),
    .wb_ack      (wb_ack),
    .rd_addr     (rd_addr),
    .slot_release(slot_release)
  );

endmodule

`default_nettype wire

// File: logic/wb_slot_port.sv
`timescale 1ns/1ns
`default_nettype none

module wb_slot_port (
  input  wire                         gmii_rx_clk,
  input  wire                         sys_rst,
  input  wire                         wb_cyc,
  input  wire                         wb_stb,
  input  wire                         wb_we,
  input  wire host_types_pkg::wb_addr_t wb_adr,
  input  wire host_types_pkg::wb_sel_t  wb_sel,
  input  wire host_types_pkg::wb_data_t wb_dat_w,
  input  wire eth_types_pkg::slot_word_t rd_data,
  input  wire                         slot_full,
  input  wire [15:0]                  drop_count,
  output host_types_pkg::wb_data_t    wb_dat_r,
  output logic                        wb_ack,
  output eth_types_pkg::slot_addr_t   rd_addr,
  output logic                        slot_release
);

  import host_types_pkg::*;

  logic     acc_start;  // first cycle of a strobe
  logic     rel_hit;
  wb_data_t status_word;

  assign acc_start = wb_cyc && wb_stb && !wb_ack;
  assign rel_hit   = wb_we && (wb_adr == '0) && wb_sel[0] && wb_dat_w[0];

  // buffer address straight from the bus, data lands in the ack cycle
  assign rd_addr = wb_adr;

  // --------------------
  // read data
  // --------------------
  always_comb begin
    status_word = '0;
    status_word[STAT_FULL_BIT] = slot_full;
    status_word[STAT_DROP_MSB:STAT_DROP_LSB] = drop_count;
  end

  assign wb_dat_r = (wb_adr == '0) ? status_word : rd_data;

  // one-cycle ack, then low for at least one cycle
  always_ff @(posedge gmii_rx_clk) begin
    if (sys_rst) begin
      wb_ack       <= 1'b0;
      slot_release <= 1'b0;
    end else begin
      wb_ack       <= acc_start;
      slot_release <= acc_start && rel_hit;  // other writes are dropped
    end
  end

  a_ack_in_cycle: assert property (@(posedge gmii_rx_clk) disable iff (sys_rst)
    wb_ack |-> wb_cyc && wb_stb);

endmodule

`default_nettype wire

// File: logic/slot_ram.sv
`timescale 1ns/1ns
`default_nettype none

`include "ethpipe_params.svh"

module slot_ram (
  input  wire                        gmii_rx_clk,
  input  wire                        wr_en,
  input  wire eth_types_pkg::slot_addr_t wr_addr,
  input  wire eth_types_pkg::slot_word_t wr_data,
  input  wire eth_types_pkg::slot_be_t   wr_be,
  input  wire eth_types_pkg::slot_addr_t rd_addr,
  output eth_types_pkg::slot_word_t  rd_data
);

  import eth_types_pkg::*;

  slot_word_t mem [`SLOT_DEPTH];

  always_ff @(posedge gmii_rx_clk) begin
    if (wr_en) begin
      for (int i = 0; i < 4; i++) begin
        if (wr_be[i]) mem[wr_addr][i*8 +: 8] <= wr_data[i*8 +: 8];
      end
    end
  end

  // registered read, one cycle
  always_ff @(posedge gmii_rx_clk) begin
    rd_data <= mem[rd_addr];
  end

endmodule

`default_nettype wire

// File: rx_port/rx_slot_ctrl.sv
`timescale 1ns/1ns
`default_nettype none

`include "ethpipe_params.svh"

module rx_slot_ctrl (
  input  wire                        gmii_rx_clk,
  input  wire                        sys_rst,
  input  wire                        gmii_rx_dv,
  input  wire eth_types_pkg::timestamp_t timestamp,
  input  wire                        frame_end,
  input  wire eth_types_pkg::frame_len_t byte_count,
  input  wire                        frame_dropped,
  input  wire                        pk_wr_en,
  input  wire eth_types_pkg::slot_addr_t pk_addr,
  input  wire eth_types_pkg::slot_word_t pk_data,
  input  wire eth_types_pkg::slot_be_t   pk_be,
  input  wire                        slot_release,
  output logic                       capture_en,
  output logic                       slot_wr_en,
  output eth_types_pkg::slot_addr_t  slot_wr_addr,
  output eth_types_pkg::slot_word_t  slot_wr_data,
  output eth_types_pkg::slot_be_t    slot_wr_be,
  output logic                       slot_full,
  output logic [15:0]                drop_count
);

  import eth_types_pkg::*;

  rx_state_t  state;
  logic [1:0] hdr_idx;
  logic       dv_q;
  timestamp_t ts_q;
  frame_len_t len_q;

  assign capture_en = (state == RX_ARMED) || (state == RX_LOAD);
  assign slot_full  = (state == RX_FULL);

  // --------------------
  // fsm
  // --------------------
  always_ff @(posedge gmii_rx_clk) begin
    if (sys_rst) begin
      state   <= RX_WAIT_IDLE;
      hdr_idx <= '0;
      dv_q    <= 1'b0;
    end else begin
      dv_q <= gmii_rx_dv;
      case (state)
        RX_WAIT_IDLE: begin
          if (!gmii_rx_dv) state <= RX_ARMED;  // never arm mid frame
        end
        RX_ARMED: begin
          if (gmii_rx_dv) state <= RX_LOAD;
        end
        RX_LOAD: begin
          if (frame_end) begin
            state   <= RX_HEADER;
            hdr_idx <= '0;
          end else if (!gmii_rx_dv && !dv_q) begin
            state <= RX_ARMED;  // line went idle without a frame
          end
        end
        RX_HEADER: begin
          hdr_idx <= hdr_idx + 1'b1;
          if (hdr_idx == 2'd3) state <= RX_FULL;
        end
        RX_FULL: begin
          if (slot_release) state <= RX_WAIT_IDLE;
        end
        default: state <= RX_WAIT_IDLE;
      endcase
    end
  end

  // arrival time and length of the stored frame
  always_ff @(posedge gmii_rx_clk) begin
    if (state == RX_ARMED && gmii_rx_dv) ts_q <= timestamp;
    if (state == RX_LOAD && frame_end) len_q <= byte_count;
  end

  // --------------------
  // write port mux
  // --------------------
  always_comb begin
    slot_wr_en   = 1'b0;
    slot_wr_addr = pk_addr;
    slot_wr_data = pk_data;
    slot_wr_be   = pk_be;
    if (state == RX_LOAD) begin
      slot_wr_en = pk_wr_en;
    end else if (state == RX_HEADER) begin
      slot_wr_en = 1'b1;
      slot_wr_be = 4'b1111;
      case (hdr_idx)
        2'd0: begin
          slot_wr_addr = slot_addr_t'(`HDR_LEN);
          slot_wr_data = slot_word_t'(len_q);
        end
        2'd1: begin
          slot_wr_addr = slot_addr_t'(`HDR_TS_LO);
          slot_wr_data = ts_q[31:0];
        end
        2'd2: begin
          slot_wr_addr = slot_addr_t'(`HDR_TS_HI);
          slot_wr_data = ts_q[63:32];
        end
        default: begin
          slot_wr_addr = slot_addr_t'(`HDR_RSVD);
          slot_wr_data = '0;  // hash word, unused here
        end
      endcase
    end
  end

  // saturating drop counter
  always_ff @(posedge gmii_rx_clk) begin
    if (sys_rst) begin
      drop_count <= '0;
    end else if (frame_dropped && drop_count != 16'hffff) begin
      drop_count <= drop_count + 16'd1;
    end
  end

  a_no_release_busy: assert property (@(posedge gmii_rx_clk) disable iff (sys_rst)
    slot_release |-> !(state inside {RX_LOAD, RX_HEADER}));

endmodule

`default_nettype wire

// File: rx_port/rx_byte_packer.sv
`timescale 1ns/1ns
`default_nettype none

`include "ethpipe_params.svh"

module rx_byte_packer (
  input  wire                        gmii_rx_clk,
  input  wire                        sys_rst,
  input  wire                        frame_start,
  input  wire                        byte_valid,
  input  wire eth_types_pkg::gmii_byte_t data_byte,
  input  wire                        frame_end,
  output logic                       pk_wr_en,
  output eth_types_pkg::slot_addr_t  pk_addr,
  output eth_types_pkg::slot_word_t  pk_data,
  output eth_types_pkg::slot_be_t    pk_be
);

  import eth_types_pkg::*;

  slot_word_t acc_data;
  slot_be_t   acc_be;
  slot_be_t   be_base;
  logic [1:0] lane;      // next free byte lane
  logic       word_rdy;  // four bytes collected last cycle

  assign be_base = word_rdy ? '0 : acc_be;

  always_ff @(posedge gmii_rx_clk) begin
    if (sys_rst) begin
      word_rdy <= 1'b0;
      acc_be   <= '0;
      lane     <= '0;
      pk_addr  <= slot_addr_t'(`DATA_BASE);
    end else if (frame_start) begin
      word_rdy <= 1'b0;
      acc_be   <= '0;
      lane     <= '0;
      pk_addr  <= slot_addr_t'(`DATA_BASE);
    end else begin
      word_rdy <= byte_valid && (lane == 2'd3);
      if (word_rdy) pk_addr <= pk_addr + 1'b1;  // next word after the write
      if (frame_end) begin
        acc_be <= '0;  // partial word goes out this cycle
        lane   <= '0;
      end else if (byte_valid) begin
        acc_be <= be_base | (4'b0001 << lane);
        lane   <= lane + 1'b1;
      end else begin
        acc_be <= be_base;
      end
    end
  end

  // lane data, masked by acc_be
  always_ff @(posedge gmii_rx_clk) begin
    if (byte_valid) acc_data[{lane, 3'b000} +: 8] <= data_byte;
  end

  assign pk_data  = acc_data;
  assign pk_be    = acc_be;
  assign pk_wr_en = word_rdy || (frame_end && (|acc_be));

  a_be_nonzero: assert property (@(posedge gmii_rx_clk) disable iff (sys_rst)
    pk_wr_en |-> pk_be != '0);

endmodule

`default_nettype wire

// File: rx_port/gmii_rx_deframer.sv
`timescale 1ns/1ns
`default_nettype none

`include "ethpipe_params.svh"

module gmii_rx_deframer (
  input  wire                        gmii_rx_clk,
  input  wire                        sys_rst,
  input  wire eth_types_pkg::gmii_byte_t gmii_rxd,
  input  wire                        gmii_rx_dv,
  input  wire                        capture_en,
  output logic                       frame_start,
  output logic                       byte_valid,
  output eth_types_pkg::gmii_byte_t  data_byte,
  output logic                       frame_end,
  output eth_types_pkg::frame_len_t  byte_count,
  output logic                       frame_dropped
);

  import eth_types_pkg::*;

  deframer_state_t state;

  always_ff @(posedge gmii_rx_clk) begin
    if (sys_rst) begin
      state         <= DF_IDLE;
      frame_start   <= 1'b0;
      byte_valid    <= 1'b0;
      frame_end     <= 1'b0;
      frame_dropped <= 1'b0;
      byte_count    <= '0;
    end else begin
      frame_start   <= 1'b0;
      byte_valid    <= 1'b0;
      frame_end     <= 1'b0;
      frame_dropped <= 1'b0;
      case (state)
        DF_IDLE, DF_PREAMBLE: begin
          if (!gmii_rx_dv) begin
            state <= DF_IDLE;
          end else if (gmii_rxd == `GMII_SFD) begin
            if (capture_en) begin
              state       <= DF_DATA;
              frame_start <= 1'b1;
              byte_count  <= '0;
            end else begin
              state         <= DF_DISCARD;  // nowhere to put it
              frame_dropped <= 1'b1;
            end
          end else if (gmii_rxd == `GMII_PREAMBLE) begin
            state <= DF_PREAMBLE;
          end else begin
            state <= DF_DISCARD;  // junk before sfd
          end
        end
        DF_DATA: begin
          if (gmii_rx_dv) begin
            byte_valid <= 1'b1;
            byte_count <= byte_count + 1'b1;
          end else begin
            state     <= DF_IDLE;
            frame_end <= 1'b1;
          end
        end
        default: begin
          if (!gmii_rx_dv) state <= DF_IDLE;
        end
      endcase
    end
  end

  // byte follows its valid strobe by the same one cycle
  always_ff @(posedge gmii_rx_clk) begin
    data_byte <= gmii_rxd;
  end

  a_frame_limit: assert property (@(posedge gmii_rx_clk) disable iff (sys_rst)
    byte_count <= frame_len_t'(`MAX_FRAME_BYTES));

endmodule

`default_nettype wire

// File: common/host_types_pkg.sv
`default_nettype none

`include "ethpipe_params.svh"

package host_types_pkg;

  typedef logic [`SLOT_ADDR_W-1:0] wb_addr_t;  // word address
  typedef logic [31:0]             wb_data_t;
  typedef logic [3:0]              wb_sel_t;

  // --------------------
  // status word 0
  // --------------------
  localparam int STAT_FULL_BIT = 0;
  localparam int STAT_DROP_LSB = 16;
  localparam int STAT_DROP_MSB = 31;

endpackage

`default_nettype wire

// File: common/eth_types_pkg.sv
`default_nettype none

`include "ethpipe_params.svh"

package eth_types_pkg;

  typedef logic [7:0]              gmii_byte_t;
  typedef logic [`SLOT_ADDR_W-1:0] slot_addr_t;
  typedef logic [31:0]             slot_word_t;
  typedef logic [3:0]              slot_be_t;    // one bit per byte lane
  typedef logic [10:0]             frame_len_t;  // bytes, fcs included
  typedef logic [63:0]             timestamp_t;

  // deframer fsm
  typedef enum logic [1:0] {
    DF_IDLE,
    DF_PREAMBLE,
    DF_DATA,
    DF_DISCARD
  } deframer_state_t;

  // slot controller fsm
  typedef enum logic [2:0] {
    RX_WAIT_IDLE,
    RX_ARMED,
    RX_LOAD,
    RX_HEADER,
    RX_FULL
  } rx_state_t;

endpackage

`default_nettype wire

// File: common/ethpipe_params.svh
`ifndef ETHPIPE_PARAMS_SVH
`define ETHPIPE_PARAMS_SVH

// --------------------
// slot geometry
// --------------------
`define SLOT_ADDR_W 11
`define SLOT_DEPTH 2048

// header word positions inside the slot
`define HDR_TS_LO 1
`define HDR_TS_HI 2
`define HDR_RSVD 3
`define HDR_LEN 4
`define DATA_BASE 5   // first frame data word

// --------------------
// gmii code bytes
// --------------------
`define GMII_PREAMBLE 8'h55
`define GMII_SFD 8'hd5

// longest frame the card accepts, fcs included
`define MAX_FRAME_BYTES 2000

`endif
